//--- psx_loader.f
psx_loader_pkg.sv
download_decoder.sv
word_packer.sv
ram_write_port.sv
media_tracker.sv
psx_loader_top.sv
tb_clock_gen.sv
psx_loader_tb.sv

//--- Bender.yml
package:
  name: psx_loader

sources:
  - psx_loader_pkg.sv
  - download_decoder.sv
  - word_packer.sv
  - ram_write_port.sv
  - media_tracker.sv
  - psx_loader_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - psx_loader_tb.sv

//--- psx_loader_tb.sv
`timescale 1ns/1ps
// ========================================
// Loader testbench with host and RAM models,
// protocol assertions and test sequence
// ========================================
module psx_loader_tb;

	// Non-default bases show that the parameters reach the packer
	localparam logic [26:0] BIOS_BASE = 27'h030_0000;
	localparam logic [26:0] EXE_BASE  = 27'h050_0000;
	localparam int          TIMEOUT   = 2000;

	logic        clk_1x;
	logic        arst_n;
	logic        ext_reset;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [26:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic        ioctl_wait;
	logic        mem_req;
	logic [26:0] mem_addr;
	logic [31:0] mem_data;
	logic        mem_ack = 1'b0;
	logic [3:0]  img_mounted;
	logic [63:0] img_size;
	logic        bk_load;
	logic        bk_save;
	logic        bk_autosave;
	logic        osd_open;
	logic        core_reset;
	logic        load_exe;
	logic        has_cd;
	logic [29:0] cd_size;
	logic        cd_hps_on;
	logic        cart_loaded;
	logic        memcard1_available;
	logic        memcard2_available;
	logic        memcard1_load;
	logic        memcard2_load;
	logic        memcard_save;

	string       test_name = "reset";
	int          errors = 0;
	int          errors_at_start;
	int          tests_run = 0;
	int          tests_failed = 0;
	logic [31:0] stim_rng = 32'h7d87;
	logic [31:0] ram_rng = 32'h7d87;
	logic [2:0]  ack_wait = 3'd0;
	logic        reset_expect = 1'b1;
	int          n_load1 = 0;
	int          n_load2 = 0;
	int          n_save = 0;
	int          n_exe = 0;
	// Scoreboard in arrival order
	logic [26:0] exp_addr[$];
	logic [31:0] exp_data[$];
	logic [26:0] got_addr[$];
	logic [31:0] got_data[$];

	tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(5)) clock_i (
		.clk_1x (clk_1x),
		.arst_n (arst_n)
	);

	psx_loader_top #(.BIOS_BASE(BIOS_BASE), .EXE_BASE(EXE_BASE)) dut_i (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// ========================================
	// RAM model answering each phase late
	// ========================================

	always @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			mem_ack  <= 1'b0;
			ack_wait <= 3'd0;
		end else if (mem_req != mem_ack) begin
			if (ack_wait == 3'd0) begin
				mem_ack <= mem_req;
				if (mem_req) begin
					got_addr.push_back(mem_addr);
					got_data.push_back(mem_data);
				end
				ram_rng = lcg_next(ram_rng);
				ack_wait <= ram_rng[19:17];
			end else begin
				ack_wait <= ack_wait - 3'd1;
			end
		end
	end

	// Core reset follows ext_reset or a download one cycle later
	always @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			reset_expect <= 1'b1;
		end else begin
			reset_expect <= ext_reset || ioctl_download;
		end
	end

	always @(posedge clk_1x) begin
		n_load1 += int'(memcard1_load);
		n_load2 += int'(memcard2_load);
		n_save  += int'(memcard_save);
		n_exe   += int'(load_exe);
	end

	task automatic note_failure(input string what);
		errors++;
		$display("%s in test %s", what, test_name);
	endtask

	// ========================================
	// Protocol and timing assertions
	// ========================================

	req_held: assert property (@(posedge clk_1x) disable iff (!arst_n)
		$fell(mem_req) |-> $past(mem_ack))
		else note_failure("mem_req fell before mem_ack rose");
	req_after_ack: assert property (@(posedge clk_1x) disable iff (!arst_n)
		$rose(mem_req) |-> !mem_ack)
		else note_failure("mem_req rose while mem_ack was high");
	host_held: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ioctl_wait |-> !ioctl_wr)
		else note_failure("host strobed while ioctl_wait was high");
	reset_follow: assert property (@(posedge clk_1x) disable iff (!arst_n)
		core_reset == reset_expect)
		else begin
			errors++;
			$display("MISMATCH %s core_reset expected %0b actual %0b", test_name,
				$sampled(reset_expect), $sampled(core_reset));
		end
	exe_timing: assert property (@(posedge clk_1x) disable iff (!arst_n)
		($fell(ioctl_download) && ioctl_index == 8'd1)
		|-> !load_exe ##1 !load_exe ##1 load_exe ##1 !load_exe)
		else note_failure("load_exe did not pulse once two cycles after the EXE end");
	card1_mount: assert property (@(posedge clk_1x) disable iff (!arst_n)
		(img_mounted[2] && img_size != 64'd0) |=> memcard1_load)
		else note_failure("card 1 mount gave no load pulse");
	card2_mount: assert property (@(posedge clk_1x) disable iff (!arst_n)
		(img_mounted[3] && img_size != 64'd0) |=> memcard2_load)
		else note_failure("card 2 mount gave no load pulse");
	menu_load: assert property (@(posedge clk_1x) disable iff (!arst_n)
		$rose(bk_load) |=> (memcard1_load && memcard2_load))
		else note_failure("bk_load did not pulse both card loads");
	menu_save: assert property (@(posedge clk_1x) disable iff (!arst_n)
		($rose(bk_save) || $rose(osd_open && bk_autosave)) |=> memcard_save)
		else note_failure("save request gave no memcard_save pulse");
	one_cycle: assert property (@(posedge clk_1x) disable iff (!arst_n)
		(memcard1_load || memcard2_load || memcard_save || load_exe)
		|=> !(memcard1_load || memcard2_load || memcard_save || load_exe))
		else note_failure("a pulse output stayed high for more than one cycle");

	// ========================================
	// Test helpers
	// ========================================

	task automatic compare_value(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		assert (actual === expected)
		else begin
			errors++;
			$display("MISMATCH %s %s expected %0h actual %0h", test_name, what,
				expected, actual);
		end
	endtask

	task automatic give_up(input string what);
		$display("Timeout in test %s: %s", test_name, what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic settle(input int n);
		repeat (n) @(posedge clk_1x);
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == errors_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic host_write(input logic [26:0] addr, input logic [15:0] data);
		int cycles;
		cycles = 0;
		@(posedge clk_1x);
		while (ioctl_wait && cycles < TIMEOUT) begin
			cycles++;
			@(posedge clk_1x);
		end
		if (cycles >= TIMEOUT) begin
			give_up("ioctl_wait never dropped");
		end
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
	endtask

	// Streams random halves, then checks every word landed once, in order
	task automatic run_download(input logic [7:0] index, input logic [26:0] start_addr,
			input int n_words, input logic [26:0] base);
		logic [15:0] lo;
		logic [15:0] hi;
		logic [26:0] addr;
		int          first;
		int          cycles;
		first  = got_addr.size();
		cycles = 0;
		@(posedge clk_1x);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
		for (int k = 0; k < n_words; k++) begin
			stim_rng = lcg_next(stim_rng);
			lo       = stim_rng[31:16];
			stim_rng = lcg_next(stim_rng);
			hi       = stim_rng[31:16];
			addr     = start_addr + 27'(k * 4);
			exp_addr.push_back(addr + base);
			exp_data.push_back({hi, lo});
			host_write(addr, lo);
			host_write(addr + 27'd2, hi);
		end
		while (got_addr.size() < first + n_words && cycles < TIMEOUT) begin
			cycles++;
			@(posedge clk_1x);
		end
		if (cycles >= TIMEOUT) begin
			give_up("RAM writes missing");
		end
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		settle(4);
		compare_value("RAM write count", first + n_words, got_addr.size());
		for (int k = first; k < first + n_words; k++) begin
			compare_value("RAM address", exp_addr[k], got_addr[k]);
			compare_value("RAM data", exp_data[k], got_data[k]);
		end
	endtask

	task automatic mount_image(input logic [3:0] bits, input logic [63:0] size);
		@(posedge clk_1x);
		img_mounted <= bits;
		img_size    <= size;
		@(posedge clk_1x);
		img_mounted <= 4'd0;
		settle(2);
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		int cycles;
		int c1;
		int c2;
		int cs;
		ext_reset      = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		img_mounted    = 4'd0;
		img_size       = 64'd0;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		bk_autosave    = 1'b0;
		osd_open       = 1'b0;
		cycles         = 0;
		while (!arst_n && cycles < TIMEOUT) begin
			cycles++;
			@(posedge clk_1x);
		end
		if (cycles >= TIMEOUT) begin
			give_up("reset was never released");
		end
		settle(2);

		start_test("bios_download");
		run_download(8'd0, 27'h100, 16, BIOS_BASE);
		end_test();

		start_test("exe_download");
		c1 = n_exe;
		run_download(8'd1, 27'h0, 4, EXE_BASE);
		settle(2);
		compare_value("load_exe pulses", c1 + 1, n_exe);
		end_test();

		start_test("core_reset");
		@(posedge clk_1x);
		ext_reset <= 1'b1;
		settle(3);
		ext_reset <= 1'b0;
		settle(3);
		compare_value("core_reset idle", 0, core_reset);
		end_test();

		start_test("cd_download_mount");
		// Download end reaches the tracker three cycles after ioctl_download falls
		run_download(8'h42, 27'h0, 3, 27'h0);
		compare_value("cd_size after download", 10, cd_size);
		compare_value("has_cd after download", 1, has_cd);
		compare_value("cd_hps_on after download", 0, cd_hps_on);
		mount_image(4'b0010, 64'h0123_4567);
		compare_value("cd_size after mount", 30'h0123_4567, cd_size);
		compare_value("has_cd after mount", 1, has_cd);
		compare_value("cd_hps_on after mount", 1, cd_hps_on);
		mount_image(4'b0010, 64'd0);
		compare_value("has_cd after empty mount", 0, has_cd);
		compare_value("cart_loaded", 1, cart_loaded);
		end_test();

		start_test("memory_cards");
		c1 = n_load1;
		c2 = n_load2;
		cs = n_save;
		mount_image(4'b0100, 64'd131072);
		compare_value("memcard1_available", 1, memcard1_available);
		mount_image(4'b1000, 64'd131072);
		compare_value("memcard2_available", 1, memcard2_available);
		compare_value("memcard1_load pulses", c1 + 1, n_load1);
		compare_value("memcard2_load pulses", c2 + 1, n_load2);
		mount_image(4'b0100, 64'd0);
		compare_value("memcard1_available after eject", 0, memcard1_available);
		compare_value("memcard1_load after eject", c1 + 1, n_load1);
		bk_load <= 1'b1;
		settle(3);
		bk_load <= 1'b0;
		bk_save <= 1'b1;
		settle(3);
		bk_save  <= 1'b0;
		osd_open <= 1'b1;
		settle(3);
		// Menu opens again with autosave on
		osd_open    <= 1'b0;
		bk_autosave <= 1'b1;
		settle(2);
		osd_open <= 1'b1;
		settle(3);
		compare_value("memcard1_load after bk_load", c1 + 2, n_load1);
		compare_value("memcard2_load after bk_load", c2 + 2, n_load2);
		compare_value("memcard_save pulses", cs + 2, n_save);
		end_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps
// ========================================
// Testbench clock and power-on reset
// ========================================
module tb_clock_gen #(
	parameter real PERIOD_NS    = 8.0,
	parameter int  RESET_CYCLES = 5
) (
	output logic clk_1x,
	output logic arst_n
);

	initial begin
		clk_1x = 1'b0;
		forever begin
			#(PERIOD_NS / 2.0) clk_1x = ~clk_1x;
		end
	end

	// Released on a rising edge after the reset cycles
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_1x);
		arst_n <= 1'b1;
	end

endmodule

//--- psx_loader_top.sv
`timescale 1ns/1ps
// ========================================
// Loader top with decoder, packer, RAM
// write port and media tracker
// ========================================
module psx_loader_top #(
	parameter logic [psx_loader_pkg::ADDR_W-1:0] BIOS_BASE = psx_loader_pkg::BIOS_BASE_DEFAULT,
	parameter logic [psx_loader_pkg::ADDR_W-1:0] EXE_BASE  = psx_loader_pkg::EXE_BASE_DEFAULT
) (
	input  logic                                 clk_1x,
	input  logic                                 arst_n,
	input  logic                                 ext_reset,
	// Host download stream
	input  logic                                 ioctl_download,
	input  logic [7:0]                           ioctl_index,
	input  logic                                 ioctl_wr,
	input  logic [psx_loader_pkg::ADDR_W-1:0]    ioctl_addr,
	input  logic [psx_loader_pkg::HALF_W-1:0]    ioctl_dout,
	output logic                                 ioctl_wait,
	// External RAM write port
	output logic                                 mem_req,
	output logic [psx_loader_pkg::ADDR_W-1:0]    mem_addr,
	output logic [psx_loader_pkg::WORD_W-1:0]    mem_data,
	input  logic                                 mem_ack,
	// Mounts and menu
	input  logic [3:0]                           img_mounted,
	input  logic [63:0]                          img_size,
	input  logic                                 bk_load,
	input  logic                                 bk_save,
	input  logic                                 bk_autosave,
	input  logic                                 osd_open,
	// Core control and status
	output logic                                 core_reset,
	output logic                                 load_exe,
	output logic                                 has_cd,
	output logic [psx_loader_pkg::CD_SIZE_W-1:0] cd_size,
	output logic                                 cd_hps_on,
	output logic                                 cart_loaded,
	output logic                                 memcard1_available,
	output logic                                 memcard2_available,
	output logic                                 memcard1_load,
	output logic                                 memcard2_load,
	output logic                                 memcard_save
);
	import psx_loader_pkg::*;

	dl_kind_e          dl_kind;
	logic              cd_done;
	logic              word_valid;
	logic [ADDR_W-1:0] word_addr;
	logic [WORD_W-1:0] word_data;
	logic              word_taken;

	download_decoder u_decoder (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ext_reset      (ext_reset),
		.dl_kind        (dl_kind),
		.exe_done       (load_exe),
		.cd_done        (cd_done),
		.core_reset     (core_reset)
	);

	word_packer #(
		.BIOS_BASE (BIOS_BASE),
		.EXE_BASE  (EXE_BASE)
	) u_packer (
		.clk_1x     (clk_1x),
		.arst_n     (arst_n),
		.dl_kind    (dl_kind),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.word_taken (word_taken),
		.word_valid (word_valid),
		.word_addr  (word_addr),
		.word_data  (word_data),
		.ioctl_wait (ioctl_wait)
	);

	ram_write_port u_write_port (
		.clk_1x     (clk_1x),
		.arst_n     (arst_n),
		.word_valid (word_valid),
		.word_addr  (word_addr),
		.word_data  (word_data),
		.mem_ack    (mem_ack),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.word_taken (word_taken)
	);

	media_tracker u_tracker (
		.clk_1x             (clk_1x),
		.arst_n             (arst_n),
		.img_mounted        (img_mounted),
		.img_size           (img_size),
		.cd_done            (cd_done),
		.ioctl_addr         (ioctl_addr),
		.dl_kind            (dl_kind),
		.bk_load            (bk_load),
		.bk_save            (bk_save),
		.bk_autosave        (bk_autosave),
		.osd_open           (osd_open),
		.has_cd             (has_cd),
		.cd_size            (cd_size),
		.cd_hps_on          (cd_hps_on),
		.cart_loaded        (cart_loaded),
		.memcard1_available (memcard1_available),
		.memcard2_available (memcard2_available),
		.memcard1_load      (memcard1_load),
		.memcard2_load      (memcard2_load),
		.memcard_save       (memcard_save)
	);

endmodule

//--- media_tracker.sv
`timescale 1ns/1ps
// ========================================
// CD and memory-card mount state with the
// memory-card load and save pulses
// ========================================
module media_tracker (
	input  logic                                 clk_1x,
	input  logic                                 arst_n,
	input  logic [3:0]                           img_mounted,
	input  logic [63:0]                          img_size,
	input  logic                                 cd_done,
	input  logic [psx_loader_pkg::ADDR_W-1:0]    ioctl_addr,
	input  psx_loader_pkg::dl_kind_e             dl_kind,
	input  logic                                 bk_load,
	input  logic                                 bk_save,
	input  logic                                 bk_autosave,
	input  logic                                 osd_open,
	output logic                                 has_cd,
	output logic [psx_loader_pkg::CD_SIZE_W-1:0] cd_size,
	output logic                                 cd_hps_on,
	output logic                                 cart_loaded,
	output logic                                 memcard1_available,
	output logic                                 memcard2_available,
	output logic                                 memcard1_load,
	output logic                                 memcard2_load,
	output logic                                 memcard_save
);
	import psx_loader_pkg::*;

	logic       size_nonzero;
	logic       save_auto;
	logic       old_load;
	logic       old_save;
	logic       old_save_auto;
	// Index 0 is card 1 on mount bit 2, index 1 is card 2 on bit 3
	logic [1:0] card_avail;
	logic [1:0] card_load;

	assign size_nonzero = (img_size != 64'd0);
	// Autosave fires when the menu opens
	assign save_auto    = osd_open && bk_autosave;

	// ========================================
	// CD image state
	// ========================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			has_cd      <= 1'b0;
			cd_size     <= '0;
			cd_hps_on   <= 1'b0;
			cart_loaded <= 1'b0;
		end else begin
			// Downloaded image, size is the final byte address
			if (cd_done) begin
				cd_size   <= CD_SIZE_W'(ioctl_addr);
				has_cd    <= 1'b1;
				cd_hps_on <= 1'b0;
			end
			// A mount overrides a download ending in the same cycle
			if (img_mounted[1]) begin
				if (size_nonzero) begin
					cd_size   <= img_size[CD_SIZE_W-1:0];
					has_cd    <= 1'b1;
					cd_hps_on <= 1'b1;
				end else begin
					has_cd <= 1'b0;
				end
			end
			if ((dl_kind == DL_EXE) || (dl_kind == DL_CD) || img_mounted[1]) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	// ========================================
	// Memory cards
	// ========================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			card_avail    <= 2'b00;
			card_load     <= 2'b00;
			memcard_save  <= 1'b0;
			old_load      <= 1'b0;
			old_save      <= 1'b0;
			old_save_auto <= 1'b0;
		end else begin
			old_load      <= bk_load;
			old_save      <= bk_save;
			old_save_auto <= save_auto;

			card_load <= 2'b00;
			for (int i = 0; i < 2; i++) begin
				if (img_mounted[i+2]) begin
					card_avail[i] <= size_nonzero;
					card_load[i]  <= size_nonzero;
				end
			end
			// Menu reload hits both cards
			if (bk_load && !old_load) begin
				card_load <= 2'b11;
			end

			memcard_save <= (bk_save && !old_save) || (save_auto && !old_save_auto);
		end
	end

	assign memcard1_available = card_avail[0];
	assign memcard2_available = card_avail[1];
	assign memcard1_load      = card_load[0];
	assign memcard2_load      = card_load[1];

endmodule

//--- ram_write_port.sv
`timescale 1ns/1ps
// ========================================
// Four-phase req/ack write master
// ========================================
module ram_write_port (
	input  logic                              clk_1x,
	input  logic                              arst_n,
	input  logic                              word_valid,
	input  logic [psx_loader_pkg::ADDR_W-1:0] word_addr,
	input  logic [psx_loader_pkg::WORD_W-1:0] word_data,
	input  logic                              mem_ack,
	output logic                              mem_req,
	output logic [psx_loader_pkg::ADDR_W-1:0] mem_addr,
	output logic [psx_loader_pkg::WORD_W-1:0] mem_data,
	output logic                              word_taken
);
	import psx_loader_pkg::*;

	wp_state_e state;
	logic      capture;

	// New word accepted only once the previous ack is gone
	assign capture = (state == WP_IDLE) && word_valid;

	// Address and data held stable for the whole handshake
	always_ff @(posedge clk_1x) begin
		if (capture) begin
			mem_addr <= word_addr;
			mem_data <= word_data;
		end
	end

	// ========================================
	// Handshake FSM
	// ========================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			state   <= WP_IDLE;
			mem_req <= 1'b0;
		end else begin
			case (state)
				WP_IDLE: begin
					if (capture) begin
						state   <= WP_REQ;
						mem_req <= 1'b1;
					end
				end
				WP_REQ: begin
					// RAM has the word, drop the request
					if (mem_ack) begin
						state   <= WP_RELEASE;
						mem_req <= 1'b0;
					end
				end
				WP_RELEASE: begin
					if (!mem_ack) begin
						state <= WP_IDLE;
					end
				end
				default: begin
					state   <= WP_IDLE;
					mem_req <= 1'b0;
				end
			endcase
		end
	end

	// Packer freed when the ack has returned low
	assign word_taken = (state == WP_RELEASE) && !mem_ack;

endmodule

//--- word_packer.sv
`timescale 1ns/1ps
// ========================================
// Word packer that joins host halves into
// RAM words at the rebased address
// ========================================
module word_packer #(
	parameter logic [psx_loader_pkg::ADDR_W-1:0] BIOS_BASE = psx_loader_pkg::BIOS_BASE_DEFAULT,
	parameter logic [psx_loader_pkg::ADDR_W-1:0] EXE_BASE  = psx_loader_pkg::EXE_BASE_DEFAULT
) (
	input  logic                                clk_1x,
	input  logic                                arst_n,
	input  psx_loader_pkg::dl_kind_e            dl_kind,
	input  logic                                ioctl_wr,
	input  logic [psx_loader_pkg::ADDR_W-1:0]   ioctl_addr,
	input  logic [psx_loader_pkg::HALF_W-1:0]   ioctl_dout,
	input  logic                                word_taken,
	output logic                                word_valid,
	output logic [psx_loader_pkg::ADDR_W-1:0]   word_addr,
	output logic [psx_loader_pkg::WORD_W-1:0]   word_data,
	output logic                                ioctl_wait
);
	import psx_loader_pkg::*;

	logic [ADDR_W-1:0] region_base;
	logic              strobe;
	logic [HALF_W-1:0] lo_half;
	logic [ADDR_W-1:0] lo_addr;
	logic              wait_q;
	logic              taken_q;

	// CD words go to the bottom of RAM
	always_comb begin
		case (dl_kind)
			DL_BIOS: region_base = BIOS_BASE;
			DL_EXE:  region_base = EXE_BASE;
			default: region_base = '0;
		endcase
	end

	// Strobes outside a known download are dropped
	assign strobe = ioctl_wr && (dl_kind != DL_NONE);

	// ========================================
	// Half and word registers
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (strobe) begin
			if (!ioctl_addr[1]) begin
				lo_half <= ioctl_dout;
				lo_addr <= ioctl_addr + region_base;
			end else begin
				// High half lands above the low half
				word_data <= {ioctl_dout, lo_half};
				word_addr <= lo_addr;
			end
		end
	end

	// ========================================
	// Valid and host wait
	// ========================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			word_valid <= 1'b0;
			wait_q     <= 1'b0;
			taken_q    <= 1'b0;
		end else begin
			taken_q <= word_taken;

			// A pending word survives the end of the download
			if (word_taken) begin
				word_valid <= 1'b0;
			end

			if (dl_kind == DL_NONE) begin
				wait_q <= 1'b0;
			end else begin
				// Host released one cycle after the word leaves
				if (taken_q) begin
					wait_q <= 1'b0;
				end
				if (strobe && ioctl_addr[1]) begin
					word_valid <= 1'b1;
					wait_q     <= 1'b1;
				end
			end
		end
	end

	// Drops in the same cycle the download ends
	assign ioctl_wait = wait_q && (dl_kind != DL_NONE);

endmodule

//--- download_decoder.sv
`timescale 1ns/1ps
// ========================================
// Download decoder with the end-of-download
// pulses and the core reset
// ========================================
module download_decoder (
	input  logic                     clk_1x,
	input  logic                     arst_n,
	input  logic                     ioctl_download,
	input  logic [7:0]               ioctl_index,
	input  logic                     ext_reset,
	output psx_loader_pkg::dl_kind_e dl_kind,
	output logic                     exe_done,
	output logic                     cd_done,
	output logic                     core_reset
);
	import psx_loader_pkg::*;

	dl_kind_e kind_next;
	// Kind one cycle behind dl_kind, for falling ends
	dl_kind_e kind_prev;

	// ========================================
	// Index decode
	// ========================================

	always_comb begin
		kind_next = DL_NONE;
		if (ioctl_download) begin
			if (ioctl_index == 8'd0) begin
				kind_next = DL_BIOS;
			end else if (ioctl_index == 8'd1) begin
				kind_next = DL_EXE;
			end else if (ioctl_index[5:0] == 6'd2) begin
				// Upper index bits select the CD drive slot
				kind_next = DL_CD;
			end
		end
	end

	// ========================================
	// Registered kind, end pulses, core reset
	// ========================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_kind    <= DL_NONE;
			kind_prev  <= DL_NONE;
			exe_done   <= 1'b0;
			cd_done    <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			dl_kind   <= kind_next;
			kind_prev <= dl_kind;

			// One cycle on the first cycle back at DL_NONE
			exe_done <= (kind_prev == DL_EXE) && (dl_kind == DL_NONE);
			cd_done  <= (kind_prev == DL_CD) && (dl_kind == DL_NONE);

			// Core stays in reset while any image is loading
			core_reset <= ext_reset || (kind_next != DL_NONE);
		end
	end

endmodule

//--- psx_loader_pkg.sv
// ========================================
// Shared widths, region bases and the
// download kind and write-port state types
// ========================================
package psx_loader_pkg;

	// ========================================
	// Widths
	// ========================================

	// Host and RAM byte address
	localparam int ADDR_W    = 27;
	// One host word
	localparam int HALF_W    = 16;
	// One RAM word, two host words packed
	localparam int WORD_W    = 32;
	// Recorded CD image size
	localparam int CD_SIZE_W = 30;

	// ========================================
	// Region bases
	// ========================================

	// BIOS image at 2 MiB
	localparam logic [ADDR_W-1:0] BIOS_BASE_DEFAULT = 27'h020_0000;
	// Executable at 4 MiB
	localparam logic [ADDR_W-1:0] EXE_BASE_DEFAULT  = 27'h040_0000;

	// ========================================
	// Types
	// ========================================

	// Kind of the running download, decoded from the host index
	typedef enum logic [1:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE,
		DL_CD
	} dl_kind_e;

	// Four-phase RAM write master
	typedef enum logic [1:0] {
		WP_IDLE,
		WP_REQ,
		WP_RELEASE
	} wp_state_e;

endpackage
